// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // ====================
    // Bus widths
    // ====================

    // Byte address of one access
    localparam int ADDR_W = 32;
    // One data beat, read or write
    localparam int DATA_W = 32;
    // Transaction tag, returned unchanged with the response
    localparam int ID_W   = 4;

    // ====================
    // Request and response
    // ====================

    // Generic request, one beat per transaction
    // Read when we is low, wdata is then don't care
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
        logic [ID_W-1:0]   id;
    } mem_req_t;

    // Generic response
    // Read data, or write acknowledge with data unused
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   id;
        // Slave or decode error
        logic              err;
        // Final beat of the transaction
        logic              last;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/proto_pkg.sv ====
`default_nettype none

package proto_pkg;

    // ====================
    // Protocol selection
    // ====================

    // Protocol code, also the lane index for codes below NUM_LANES
    typedef enum logic [1:0] {
        PROTO_AXI4   = 2'd0,
        PROTO_CHI    = 2'd1,
        PROTO_TL     = 2'd2,
        PROTO_CUSTOM = 2'd3
    } proto_e;

    // External lanes, one per real protocol
    localparam int NUM_LANES  = 3;
    // Request buffer entries per lane
    localparam int LANE_DEPTH = 2;
    // Counters and status word
    localparam int CNT_W      = 32;

    // ====================
    // Configuration word
    // ====================
    localparam int CFG_W         = 32;
    localparam int CFG_PROTO_LSB = 0;
    localparam int CFG_EN_BIT    = 2;
    localparam int CFG_DBG_BIT   = 3;
    localparam int CFG_OPT_LSB   = 8;
    localparam int CFG_OPT_MSB   = 15;

    // Status word layout
    localparam int STS_PROTO_LSB = 0;
    localparam int STS_OPT_LSB   = 2;
    localparam int STS_CNTL_LSB  = 8;
    localparam int STS_DBG_BIT   = 14;
    localparam int STS_EN_BIT    = 15;
    localparam int STS_CNTH_LSB  = 16;

    // Dispatch stage to lane, valid for one cycle per request
    typedef struct packed {
        logic              valid;
        mem_pkg::mem_req_t req;
    } lane_req_t;

endpackage

`default_nettype wire

// ==== rtl/req_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_dispatch (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic [proto_pkg::CFG_W-1:0]          config_i,
    input  logic                                 req_valid_i,
    input  mem_pkg::mem_req_t                    req_i,
    output logic                                 req_ready_o,
    input  logic [proto_pkg::NUM_LANES-1:0]      lane_space_i,
    input  logic                                 loop_space_i,
    output proto_pkg::lane_req_t                 lane_req_o [proto_pkg::NUM_LANES],
    output proto_pkg::lane_req_t                 loop_req_o,
    output proto_pkg::proto_e                    proto_o
);

    import mem_pkg::*;
    import proto_pkg::*;

    // ====================
    // Config decode
    // ====================
    proto_e cfg_proto;
    logic   cfg_en;

    assign cfg_proto = proto_e'(config_i[CFG_PROTO_LSB +: 2]);
    assign cfg_en    = config_i[CFG_EN_BIT];

    // Registered copy, takes effect one cycle after a config change
    proto_e proto_q;
    logic   en_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            proto_q <= PROTO_AXI4;
            en_q    <= 1'b0;
        end else begin
            proto_q <= cfg_proto;
            en_q    <= cfg_en;
        end
    end

    assign proto_o = proto_q;

    // Space of the current target, loopback register for custom
    logic sel_space;

    always_comb begin
        if (proto_q == PROTO_CUSTOM) begin
            sel_space = loop_space_i;
        end else begin
            sel_space = lane_space_i[proto_q];
        end
    end

    assign req_ready_o = en_q & sel_space;

    // ====================
    // Dispatch stage
    // ====================
    logic     stg_valid_q;
    proto_e   stg_tgt_q;
    mem_req_t stg_req_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stg_valid_q <= 1'b0;
            stg_tgt_q   <= PROTO_AXI4;
        end else begin
            // Single cycle hold, target tagged at acceptance
            stg_valid_q <= req_valid_i & req_ready_o;
            if (req_valid_i && req_ready_o) begin
                stg_tgt_q <= proto_q;
            end
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            stg_req_q <= req_i;
        end
    end

    // Steering, payload shared and valid decoded per target
    logic [NUM_LANES-1:0] lane_vld;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_steer
        assign lane_vld[i]         = stg_valid_q && (stg_tgt_q == proto_e'(i));
        assign lane_req_o[i].valid = lane_vld[i];
        assign lane_req_o[i].req   = stg_req_q;
    end

    assign loop_req_o.valid = stg_valid_q && (stg_tgt_q == PROTO_CUSTOM);
    assign loop_req_o.req   = stg_req_q;

    // One target per dispatched request
    a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({loop_req_o.valid, lane_vld}));

    // No dispatch while the switch is disabled
    a_en_before_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (loop_req_o.valid || (|lane_vld)) |-> en_q);

endmodule

`default_nettype wire

// ==== rtl/port_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_lane (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  proto_pkg::lane_req_t in_i,
    output logic                 space_o,
    output logic                 lane_req_valid_o,
    output mem_pkg::mem_req_t    lane_req_o,
    input  logic                 lane_req_ready_i,
    input  logic                 lane_rsp_valid_i,
    input  mem_pkg::mem_rsp_t    lane_rsp_i,
    output logic                 lane_rsp_ready_o,
    output logic                 rsp_valid_o,
    output mem_pkg::mem_rsp_t    rsp_o,
    input  logic                 rsp_take_i
);

    import mem_pkg::*;
    import proto_pkg::*;

    localparam int PTR_W  = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
    localparam int FILL_W = $clog2(LANE_DEPTH + 1);

    // ====================
    // Request FIFO
    // ====================
    mem_req_t          buf_q [LANE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [FILL_W-1:0] fill_q;
    logic              push;
    logic              pop;

    assign push = in_i.valid;
    assign pop  = lane_req_valid_o & lane_req_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            fill_q <= fill_q + FILL_W'(push) - FILL_W'(pop);
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= in_i.req;
        end
    end

    // Oldest entry goes out first
    assign lane_req_valid_o = (fill_q != '0);
    assign lane_req_o       = buf_q[rd_ptr_q];

    // Entry in the dispatch stage already counts as taken
    assign space_o = (int'(fill_q) + int'(in_i.valid)) < LANE_DEPTH;

    // Response path, no storage here
    assign rsp_valid_o      = lane_rsp_valid_i;
    assign rsp_o            = lane_rsp_i;
    assign lane_rsp_ready_o = rsp_take_i;

    // Dispatch must honour the space flag
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_i.valid |-> (int'(fill_q) < LANE_DEPTH));

endmodule

`default_nettype wire

// ==== rtl/rsp_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsp_collect (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  proto_pkg::proto_e               proto_i,
    input  logic [proto_pkg::NUM_LANES-1:0] lane_rsp_valid_i,
    input  mem_pkg::mem_rsp_t               lane_rsp_i [proto_pkg::NUM_LANES],
    output logic [proto_pkg::NUM_LANES-1:0] lane_take_o,
    input  proto_pkg::lane_req_t            loop_req_i,
    output logic                            loop_space_o,
    output logic                            rsp_valid_o,
    output mem_pkg::mem_rsp_t               rsp_o,
    input  logic                            rsp_ready_i
);

    import mem_pkg::*;
    import proto_pkg::*;

    // ====================
    // Custom loopback
    // ====================
    logic     loop_valid_q;
    mem_rsp_t loop_rsp_q;
    logic     loop_take;

    // Drained only while custom is selected
    assign loop_take = (proto_i == PROTO_CUSTOM) & loop_valid_q & rsp_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            loop_valid_q <= 1'b0;
        end else if (loop_req_i.valid) begin
            loop_valid_q <= 1'b1;
        end else if (loop_take) begin
            loop_valid_q <= 1'b0;
        end
    end

    // Echo the address back as read data
    always_ff @(posedge clk_i) begin
        if (loop_req_i.valid) begin
            loop_rsp_q.data <= DATA_W'(loop_req_i.req.addr);
            loop_rsp_q.id   <= loop_req_i.req.id;
            loop_rsp_q.err  <= 1'b0;
            loop_rsp_q.last <= 1'b1;
        end
    end

    // One entry, an arriving request fills it
    assign loop_space_o = ~loop_valid_q & ~loop_req_i.valid;

    // ====================
    // Response select
    // ====================
    always_comb begin
        lane_take_o = '0;
        if (proto_i == PROTO_CUSTOM) begin
            rsp_valid_o = loop_valid_q;
            rsp_o       = loop_rsp_q;
        end else begin
            rsp_valid_o = lane_rsp_valid_i[proto_i];
            rsp_o       = lane_rsp_i[proto_i];
            // Handshake back to the selected lane only
            lane_take_o[proto_i] = lane_rsp_valid_i[proto_i] & rsp_ready_i;
        end
    end

    // Stalled response holds, unless the protocol was switched
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rsp_valid_o && !rsp_ready_i) |=>
            ($changed(proto_i) || (rsp_valid_o && $stable(rsp_o))));

endmodule

`default_nettype wire

// ==== rtl/perf_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module perf_status (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic [proto_pkg::CFG_W-1:0] config_i,
    input  logic                        req_fire_i,
    input  logic                        rsp_fire_i,
    output logic [proto_pkg::CNT_W-1:0] trans_cnt_o,
    output logic [proto_pkg::CNT_W-1:0] beat_cnt_o,
    output logic [proto_pkg::CNT_W-1:0] lat_avg_o,
    output logic [proto_pkg::CNT_W-1:0] status_o
);

    import proto_pkg::*;

    // ====================
    // Counters
    // ====================
    logic [CNT_W-1:0] trans_q;
    logic [CNT_W-1:0] beat_q;
    logic [CNT_W-1:0] timer_q;
    logic [CNT_W-1:0] acc_q;
    logic             pending_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trans_q   <= '0;
            beat_q    <= '0;
            timer_q   <= '0;
            acc_q     <= '0;
            pending_q <= 1'b0;
        end else begin
            if (req_fire_i) begin
                trans_q <= trans_q + 1'b1;
            end
            if (rsp_fire_i) begin
                beat_q <= beat_q + 1'b1;
            end
            // Latency of the most recent request only
            if (req_fire_i) begin
                timer_q <= '0;
            end else if (pending_q) begin
                timer_q <= timer_q + 1'b1;
            end
            // First beat after acceptance closes the measurement
            if (rsp_fire_i && pending_q) begin
                acc_q <= acc_q + timer_q;
            end
            if (req_fire_i) begin
                pending_q <= 1'b1;
            end else if (rsp_fire_i) begin
                pending_q <= 1'b0;
            end
        end
    end

    assign trans_cnt_o = trans_q;
    assign beat_cnt_o  = beat_q;
    assign lat_avg_o   = (trans_q != '0) ? acc_q / trans_q : '0;

    // ====================
    // Status word
    // ====================
    logic [7:0] cfg_opt;

    assign cfg_opt = config_i[CFG_OPT_MSB:CFG_OPT_LSB];

    always_comb begin
        status_o = '0;
        status_o[STS_PROTO_LSB +: 2] = config_i[CFG_PROTO_LSB +: 2];
        // Upper six option bits
        status_o[STS_OPT_LSB +: 6]   = cfg_opt[7:2];
        status_o[STS_CNTL_LSB +: 4]  = trans_q[11:8];
        status_o[STS_DBG_BIT]        = config_i[CFG_DBG_BIT];
        status_o[STS_EN_BIT]         = config_i[CFG_EN_BIT];
        status_o[STS_CNTH_LSB +: 8]  = trans_q[23:16];
    end

endmodule

`default_nettype wire

// ==== rtl/protocol_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

module protocol_switch (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic [proto_pkg::CFG_W-1:0]     config_i,
    output logic [proto_pkg::CNT_W-1:0]     status_o,
    // Generic memory port
    input  logic                            req_valid_i,
    input  mem_pkg::mem_req_t               req_i,
    output logic                            req_ready_o,
    output logic                            rsp_valid_o,
    output mem_pkg::mem_rsp_t               rsp_o,
    input  logic                            rsp_ready_i,
    // External lanes, AXI4, CHI, TileLink
    output logic [proto_pkg::NUM_LANES-1:0] lane_req_valid_o,
    output mem_pkg::mem_req_t               lane_req_o [proto_pkg::NUM_LANES],
    input  logic [proto_pkg::NUM_LANES-1:0] lane_req_ready_i,
    input  logic [proto_pkg::NUM_LANES-1:0] lane_rsp_valid_i,
    input  mem_pkg::mem_rsp_t               lane_rsp_i [proto_pkg::NUM_LANES],
    output logic [proto_pkg::NUM_LANES-1:0] lane_rsp_ready_o,
    // Performance counters
    output logic [proto_pkg::CNT_W-1:0]     trans_cnt_o,
    output logic [proto_pkg::CNT_W-1:0]     beat_cnt_o,
    output logic [proto_pkg::CNT_W-1:0]     lat_avg_o
);

    import mem_pkg::*;
    import proto_pkg::*;

    // ====================
    // Internal wires
    // ====================
    lane_req_t            lane_in [NUM_LANES];
    logic [NUM_LANES-1:0] lane_space;
    logic [NUM_LANES-1:0] lane_up_valid;
    mem_rsp_t             lane_up_rsp [NUM_LANES];
    logic [NUM_LANES-1:0] lane_take;
    lane_req_t            loop_req;
    logic                 loop_space;
    proto_e               proto_q;
    logic                 req_fire;
    logic                 rsp_fire;

    // Generic port handshakes
    assign req_fire = req_valid_i & req_ready_o;
    assign rsp_fire = rsp_valid_o & rsp_ready_i;

    req_dispatch u_dispatch (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .config_i     (config_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .lane_space_i (lane_space),
        .loop_space_i (loop_space),
        .lane_req_o   (lane_in),
        .loop_req_o   (loop_req),
        .proto_o      (proto_q)
    );

    // One buffered lane per external protocol port
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        port_lane u_lane (
            .clk_i            (clk_i),
            .rst_ni           (rst_ni),
            .in_i             (lane_in[i]),
            .space_o          (lane_space[i]),
            .lane_req_valid_o (lane_req_valid_o[i]),
            .lane_req_o       (lane_req_o[i]),
            .lane_req_ready_i (lane_req_ready_i[i]),
            .lane_rsp_valid_i (lane_rsp_valid_i[i]),
            .lane_rsp_i       (lane_rsp_i[i]),
            .lane_rsp_ready_o (lane_rsp_ready_o[i]),
            .rsp_valid_o      (lane_up_valid[i]),
            .rsp_o            (lane_up_rsp[i]),
            .rsp_take_i       (lane_take[i])
        );
    end

    rsp_collect u_collect (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .proto_i          (proto_q),
        .lane_rsp_valid_i (lane_up_valid),
        .lane_rsp_i       (lane_up_rsp),
        .lane_take_o      (lane_take),
        .loop_req_i       (loop_req),
        .loop_space_o     (loop_space),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_o            (rsp_o),
        .rsp_ready_i      (rsp_ready_i)
    );

    perf_status u_perf (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .config_i    (config_i),
        .req_fire_i  (req_fire),
        .rsp_fire_i  (rsp_fire),
        .trans_cnt_o (trans_cnt_o),
        .beat_cnt_o  (beat_cnt_o),
        .lat_avg_o   (lat_avg_o),
        .status_o    (status_o)
    );

endmodule

`default_nettype wire

// ==== sim/protocol_switch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module protocol_switch_tb;

    import mem_pkg::*;
    import proto_pkg::*;

    // Cycles allowed for one wait loop
    localparam int TMO = 4000;

    // ====================
    // DUT signals
    // ====================
    logic                 clk_i = 1'b0;
    logic                 rst_ni = 1'b0;
    logic [31:0]          config_i;
    logic [31:0]          status_o;
    logic                 req_valid_i;
    mem_req_t             req_i;
    logic                 req_ready_o;
    logic                 rsp_valid_o;
    mem_rsp_t             rsp_o;
    logic                 rsp_ready_i;
    logic [NUM_LANES-1:0] lane_req_valid_o;
    mem_req_t             lane_req_o [NUM_LANES];
    logic [NUM_LANES-1:0] lane_req_ready_i;
    logic [NUM_LANES-1:0] lane_rsp_valid_i;
    mem_rsp_t             lane_rsp_i [NUM_LANES];
    logic [NUM_LANES-1:0] lane_rsp_ready_o;
    logic [31:0]          trans_cnt_o;
    logic [31:0]          beat_cnt_o;
    logic [31:0]          lat_avg_o;

    // Stimulus control, written by the test sequence
    logic [31:0] goal;
    logic        bp;
    logic        single;
    logic [31:0] lfsr = 32'hc428_38f6;

    // Model state
    logic [31:0] cfg_q;
    mem_req_t    sb_q [NUM_LANES][$];
    mem_req_t    sb_front [NUM_LANES];
    int          sb_cnt [NUM_LANES];
    mem_rsp_t    exp_q [$];
    mem_rsp_t    rsp_front;
    int          rsp_cnt;
    logic [31:0] trans_exp;
    logic [31:0] beat_exp;
    logic [31:0] cyc;
    logic [31:0] last_acc;
    logic        lat_pend;
    logic [31:0] lat_acc;
    logic [31:0] lat_exp;
    logic [31:0] status_exp;
    int          err_cnt = 0;
    int          test_cnt = 0;

    protocol_switch protocol_switch_i (.*);

    initial begin
        forever #2 clk_i = ~clk_i;
    end

    // ====================
    // Helpers
    // ====================
    // Galois LFSR, one step per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] got);
        err_cnt++;
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, got);
    endtask

    task automatic report_error(input string what);
        err_cnt++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("[%0t] test %0d %s finished, %0d errors so far", $time, test_cnt, name,
                 err_cnt);
    endtask

    // ====================
    // Driver and lane responders
    // ====================
    always @(posedge clk_i) begin : drive
        mem_req_t r;
        mem_rsp_t rsp;
        mem_req_t pend [NUM_LANES][$];
        logic     fire_now;
        logic     taken;
        if (!rst_ni) begin
            req_valid_i      <= 1'b0;
            rsp_ready_i      <= 1'b0;
            lane_req_ready_i <= '0;
            lane_rsp_valid_i <= '0;
            foreach (pend[i]) pend[i].delete();
        end else begin
            fire_now = req_valid_i && req_ready_o;
            // Waiting request stays as it is
            if (!req_valid_i || fire_now) begin
                if ((trans_exp + 32'(fire_now) < goal) &&
                    (!single || (rsp_cnt == 0 && !fire_now)) && next_bit()) begin
                    r.addr  = rand_bits(32);
                    r.wdata = rand_bits(32);
                    r.we    = next_bit();
                    r.id    = ID_W'(rand_bits(ID_W));
                    req_i       <= r;
                    req_valid_i <= 1'b1;
                end else begin
                    req_valid_i <= 1'b0;
                end
            end
            rsp_ready_i <= bp ? next_bit() : 1'b1;
            for (int i = 0; i < NUM_LANES; i++) begin
                taken = lane_rsp_valid_i[i] && lane_rsp_ready_o[i];
                if (lane_req_valid_o[i] && lane_req_ready_i[i]) begin
                    pend[i].push_back(lane_req_o[i]);
                end
                if (taken) begin
                    void'(pend[i].pop_front());
                end
                // Response of the oldest request, held until taken
                if (!lane_rsp_valid_i[i] || taken) begin
                    if (pend[i].size() != 0 && (!bp || next_bit())) begin
                        r        = pend[i][0];
                        rsp.data = ~r.addr;
                        rsp.id   = r.id;
                        rsp.err  = 1'b0;
                        rsp.last = 1'b1;
                        lane_rsp_i[i]       <= rsp;
                        lane_rsp_valid_i[i] <= 1'b1;
                    end else begin
                        lane_rsp_valid_i[i] <= 1'b0;
                    end
                end
                lane_req_ready_i[i] <= bp ? next_bit() : 1'b1;
            end
        end
    end

    // ====================
    // Reference model
    // ====================
    always @(posedge clk_i or negedge rst_ni) begin : model
        mem_rsp_t e;
        logic     req_fire;
        logic     rsp_fire;
        if (!rst_ni) begin
            cfg_q     <= '0;
            trans_exp <= '0;
            beat_exp  <= '0;
            cyc       <= '0;
            last_acc  <= '0;
            lat_pend  <= 1'b0;
            lat_acc   <= '0;
            rsp_front <= '0;
            rsp_cnt   <= 0;
            exp_q.delete();
            foreach (sb_q[i]) begin
                sb_q[i].delete();
                sb_front[i] <= '0;
                sb_cnt[i]   <= 0;
            end
        end else begin
            req_fire = req_valid_i && req_ready_o;
            rsp_fire = rsp_valid_o && rsp_ready_i;
            // Protocol and enable act one cycle after the config word
            cfg_q <= config_i;
            cyc   <= cyc + 1;
            if (req_fire) begin
                trans_exp <= trans_exp + 1;
                e.id   = req_i.id;
                e.err  = 1'b0;
                e.last = 1'b1;
                if (cfg_q[1:0] == 2'd3) begin
                    e.data = req_i.addr;
                end else begin
                    e.data = ~req_i.addr;
                    sb_q[cfg_q[1:0]].push_back(req_i);
                end
                exp_q.push_back(e);
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (lane_req_valid_o[i] && lane_req_ready_i[i] && sb_q[i].size() != 0) begin
                    void'(sb_q[i].pop_front());
                end
                sb_front[i] <= (sb_q[i].size() != 0) ? sb_q[i][0] : '0;
                sb_cnt[i]   <= sb_q[i].size();
            end
            if (rsp_fire) begin
                beat_exp <= beat_exp + 1;
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
            end
            rsp_front <= (exp_q.size() != 0) ? exp_q[0] : '0;
            rsp_cnt   <= exp_q.size();
            // Latency: cycles after acceptance up to the first beat
            if (rsp_fire && lat_pend) begin
                lat_acc <= lat_acc + (cyc - last_acc - 1);
            end
            if (req_fire) begin
                last_acc <= cyc;
                lat_pend <= 1'b1;
            end else if (rsp_fire) begin
                lat_pend <= 1'b0;
            end
        end
    end

    always_comb begin
        lat_exp = (trans_exp != 0) ? lat_acc / trans_exp : '0;
        status_exp        = '0;
        status_exp[1:0]   = config_i[1:0];
        status_exp[7:2]   = config_i[15:10];
        status_exp[11:8]  = trans_exp[11:8];
        status_exp[14]    = config_i[3];
        status_exp[15]    = config_i[2];
        status_exp[23:16] = trans_exp[23:16];
    end

    // ====================
    // Assertions
    // ====================
    a_reset_idle: assert property (@(posedge clk_i) $rose(rst_ni) |->
        (!req_ready_o && lane_req_valid_o == '0 && lane_rsp_ready_o == '0 && !rsp_valid_o &&
         trans_cnt_o == '0 && beat_cnt_o == '0 && lat_avg_o == '0))
        else report_error("outputs or counters not idle after reset");

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane_chk
        // Requests leave the lane in acceptance order
        a_lane_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
            (lane_req_valid_o[i] && lane_req_ready_i[i]) |-> lane_req_o[i] == sb_front[i])
            else report_mismatch($sformatf("lane_req_o[%0d]", i), $sampled(sb_front[i]),
                                 $sampled(lane_req_o[i]));
        a_lane_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
            lane_req_valid_o[i] |-> sb_cnt[i] != 0)
            else report_error($sformatf("lane %0d shows a request it was never sent", i));
    end

    a_rsp_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rsp_valid_o && rsp_ready_i) |-> rsp_o == rsp_front)
        else report_mismatch("rsp_o", $sampled(rsp_front), $sampled(rsp_o));
    a_rsp_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o |-> rsp_cnt != 0)
        else report_error("response valid without an outstanding request");
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
        else report_error("stalled response dropped or changed");
    a_en_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !cfg_q[2] |-> !req_ready_o)
        else report_error("request ready while the switch is disabled");
    a_trans: assert property (@(posedge clk_i) disable iff (!rst_ni) trans_cnt_o == trans_exp)
        else report_mismatch("trans_cnt_o", $sampled(trans_exp), $sampled(trans_cnt_o));
    a_beat: assert property (@(posedge clk_i) disable iff (!rst_ni) beat_cnt_o == beat_exp)
        else report_mismatch("beat_cnt_o", $sampled(beat_exp), $sampled(beat_cnt_o));
    a_lat: assert property (@(posedge clk_i) disable iff (!rst_ni) lat_avg_o == lat_exp)
        else report_mismatch("lat_avg_o", $sampled(lat_exp), $sampled(lat_avg_o));
    a_status: assert property (@(posedge clk_i) disable iff (!rst_ni) status_o == status_exp)
        else report_mismatch("status_o", $sampled(status_exp), $sampled(status_o));

    // ====================
    // Test sequence
    // ====================
    task automatic run_traffic(input string name, input logic [31:0] cfg, input int n,
                               input logic back, input logic one);
        int t;
        @(posedge clk_i);
        config_i <= cfg;
        bp       <= back;
        single   <= one;
        repeat (2) @(posedge clk_i);
        goal <= trans_exp + n;
        @(posedge clk_i);
        t = 0;
        // All requests accepted and every response returned
        while ((trans_exp < goal || rsp_cnt != 0) && t < TMO) begin
            @(posedge clk_i);
            t++;
        end
        if (t >= TMO) begin
            report_error({name, ": traffic did not drain before the timeout"});
        end
        finish_test(name);
    endtask

    initial begin
        config_i    = '0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b0;
        goal        = '0;
        bp          = 1'b0;
        single      = 1'b0;
        lane_req_ready_i = '0;
        lane_rsp_valid_i = '0;
        foreach (lane_rsp_i[i]) lane_rsp_i[i] = '0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        finish_test("reset");
        run_traffic("axi4 lane", 32'h0000_0004, 90, 1'b1, 1'b0);
        run_traffic("chi lane", 32'h0000_0005, 90, 1'b1, 1'b0);
        run_traffic("tilelink lane", 32'h0000_0006, 90, 1'b1, 1'b0);
        run_traffic("custom loopback", 32'h0000_0007, 40, 1'b1, 1'b0);
        // One request in flight, debug and option bits set
        run_traffic("latency and status", 32'h0000_ab0d, 20, 1'b1, 1'b1);
        // Request offered while disabled is never taken
        run_traffic("disabled", 32'h0000_c301, 0, 1'b1, 1'b0);
        goal <= trans_exp + 1;
        repeat (40) @(posedge clk_i);
        finish_test("disabled hold");
        $display("Summary: %0d tests, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== protocol_switch.f ====
rtl/mem_pkg.sv
rtl/proto_pkg.sv
rtl/req_dispatch.sv
rtl/port_lane.sv
rtl/rsp_collect.sv
rtl/perf_status.sv
rtl/protocol_switch.sv
sim/protocol_switch_tb.sv
